//--- src/cnn_ctrl.sv
`timescale 1ns/1ps

module cnn_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid_i,
    input  logic                    mode_i,
    output cnn_pkg::load_ctrl_t     load_o,
    output cnn_pkg::act_mode_t      mode_o,
    output cnn_pkg::conv_cmd_t      cmd_o
);

    logic [6:0]             sample_cnt;
    logic [6:0]             pix_n;
    cnn_pkg::act_mode_t     mode_q;
    logic                   scan_start;
    logic                   scan_busy;
    logic                   scan_img;
    logic [3:0]             scan_pos;

    // ==================================================================
    // sample counter and input decode
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sample_cnt <= '0;
        else if (in_valid_i)
            sample_cnt <= sample_cnt + 7'd1;
        else
            sample_cnt <= '0;   // gap ends the transaction
    end

    assign pix_n = (sample_cnt >= 7'(cnn_pkg::IMG_SAMPLES)) ?
                   sample_cnt - 7'(cnn_pkg::IMG_SAMPLES) : sample_cnt;

    always_comb
    begin
        load_o.ker_we  = in_valid_i && (sample_cnt < 7'(cnn_pkg::KER_SAMPLES));
        load_o.ker_idx = sample_cnt[3:0];
        load_o.wgt_we  = in_valid_i && (sample_cnt < 7'(cnn_pkg::WEIGHT_SAMPLES));
        load_o.wgt_row = sample_cnt[4:3];   // row-major, 8 per row
        load_o.wgt_col = sample_cnt[2:0];
        load_o.pix_we  = in_valid_i && (sample_cnt < 7'(cnn_pkg::TXN_SAMPLES));
        load_o.img_sel = (sample_cnt >= 7'(cnn_pkg::IMG_SAMPLES));
        load_o.img_row = 3'(pix_n / 7'(cnn_pkg::IMG_DIM));
        load_o.img_col = 3'(pix_n % 7'(cnn_pkg::IMG_DIM));
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            mode_q <= cnn_pkg::ACT_RELU;
        else if (in_valid_i && (sample_cnt == 7'd0))
            mode_q <= cnn_pkg::act_mode_t'(mode_i);
    end

    assign mode_o = mode_q;

    // ==================================================================
    // convolution scan, 16 positions after each image
    // ==================================================================
    assign scan_start = in_valid_i &&
                        ((sample_cnt == 7'(cnn_pkg::IMG_SAMPLES - 1)) ||
                         (sample_cnt == 7'(cnn_pkg::TXN_SAMPLES - 1)));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scan_busy <= 1'b0;
            scan_img  <= 1'b0;
            scan_pos  <= '0;
        end
        else if (scan_start)
        begin
            scan_busy <= 1'b1;
            scan_img  <= (sample_cnt == 7'(cnn_pkg::TXN_SAMPLES - 1));
            scan_pos  <= '0;
        end
        else if (scan_busy)
        begin
            scan_pos <= scan_pos + 4'd1;
            if (scan_pos == 4'(cnn_pkg::FMAP_DIM * cnn_pkg::FMAP_DIM - 1))
                scan_busy <= 1'b0;
        end
    end

    always_comb
    begin
        cmd_o.valid   = scan_busy;
        cmd_o.img_sel = scan_img;
        cmd_o.row     = scan_pos[3:2];
        cmd_o.col     = scan_pos[1:0];
    end

endmodule

//--- src/cnn_pkg.sv
package cnn_pkg;

    // ==================================================================
    // sizes
    // ==================================================================
    localparam int IMG_DIM  = 6;
    localparam int KER_DIM  = 3;
    localparam int FMAP_DIM = IMG_DIM - KER_DIM + 1;    // valid convolution
    localparam int POOL_DIM = 2;
    localparam int N_IMAGES = 2;
    localparam int N_FEAT   = 8;
    localparam int N_OUT    = 4;

    // input schedule, in samples
    localparam int KER_SAMPLES    = KER_DIM * KER_DIM;
    localparam int WEIGHT_SAMPLES = N_OUT * N_FEAT;
    localparam int IMG_SAMPLES    = IMG_DIM * IMG_DIM;
    localparam int TXN_SAMPLES    = N_IMAGES * IMG_SAMPLES;

    localparam int QUANT_SHIFT = 9;
    localparam int QUANT_MAX   = 127;

    // ==================================================================
    // types
    // ==================================================================
    typedef logic signed [7:0]  pixel_t;
    typedef logic signed [19:0] conv_sum_t;
    typedef logic signed [20:0] fmap_t;
    typedef logic signed [19:0] out_t;

    typedef enum logic {ACT_RELU = 1'b0, ACT_ABS = 1'b1} act_mode_t;

    typedef struct packed {
        logic                               ker_we;
        logic [$clog2(KER_SAMPLES)-1:0]     ker_idx;
        logic                               wgt_we;
        logic [$clog2(N_OUT)-1:0]           wgt_row;
        logic [$clog2(N_FEAT)-1:0]          wgt_col;
        logic                               pix_we;
        logic                               img_sel;    // 0 image 1, 1 image 2
        logic [$clog2(IMG_DIM)-1:0]         img_row;
        logic [$clog2(IMG_DIM)-1:0]         img_col;
    } load_ctrl_t;

    typedef struct packed {
        logic                               valid;
        logic                               img_sel;
        logic [$clog2(FMAP_DIM)-1:0]        row;
        logic [$clog2(FMAP_DIM)-1:0]        col;
    } conv_cmd_t;

    typedef struct packed {
        logic                               valid;
        pixel_t [N_FEAT-1:0]                feat;       // feat[0] is image 1 window 0
    } pooled_vec_t;

endpackage

//--- src/cnn_top.sv
`timescale 1ns/1ps

module cnn_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid_i,
    input  logic                mode_i,
    input  cnn_pkg::pixel_t     in_data_ch1_i,
    input  cnn_pkg::pixel_t     in_data_ch2_i,
    input  cnn_pkg::pixel_t     kernel_ch1_i,
    input  cnn_pkg::pixel_t     kernel_ch2_i,
    input  cnn_pkg::pixel_t     weight_i,
    output logic                out_valid_o,
    output cnn_pkg::out_t       out_data_o
);

    cnn_pkg::load_ctrl_t    load;
    cnn_pkg::act_mode_t     mode;
    cnn_pkg::conv_cmd_t     cmd;
    cnn_pkg::conv_sum_t     sum_ch1;
    cnn_pkg::conv_sum_t     sum_ch2;
    cnn_pkg::pooled_vec_t   pooled;

    cnn_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (in_valid_i),
        .mode_i     (mode_i),
        .load_o     (load),
        .mode_o     (mode),
        .cmd_o      (cmd)
    );

    // ==================================================================
    // two channels side by side
    // ==================================================================
    conv_channel u_conv_ch1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_i     (load),
        .pixel_i    (in_data_ch1_i),
        .kernel_i   (kernel_ch1_i),
        .cmd_i      (cmd),
        .sum_o      (sum_ch1)
    );

    conv_channel u_conv_ch2 (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_i     (load),
        .pixel_i    (in_data_ch2_i),
        .kernel_i   (kernel_ch2_i),
        .cmd_i      (cmd),
        .sum_o      (sum_ch2)
    );

    feature_pool u_pool (
        .clk        (clk),
        .rst_n      (rst_n),
        .mode_i     (mode),
        .cmd_i      (cmd),
        .sum_a_i    (sum_ch1),
        .sum_b_i    (sum_ch2),
        .pooled_o   (pooled)
    );

    dense_layer u_dense (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_i      (load),
        .weight_i    (weight_i),
        .pooled_i    (pooled),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o)
    );

endmodule

//--- src/conv_channel.sv
`timescale 1ns/1ps

module conv_channel (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cnn_pkg::load_ctrl_t     load_i,
    input  cnn_pkg::pixel_t         pixel_i,
    input  cnn_pkg::pixel_t         kernel_i,
    input  cnn_pkg::conv_cmd_t      cmd_i,
    output cnn_pkg::conv_sum_t      sum_o
);

    cnn_pkg::pixel_t    ker_q [cnn_pkg::KER_SAMPLES];
    cnn_pkg::pixel_t    img_q [cnn_pkg::N_IMAGES][cnn_pkg::IMG_DIM][cnn_pkg::IMG_DIM];
    cnn_pkg::conv_sum_t mac_sum;
    cnn_pkg::conv_sum_t sum_q;

    // ==================================================================
    // kernel and double image buffer
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (load_i.ker_we)
            ker_q[load_i.ker_idx] <= kernel_i;
    end

    // one buffer fills while the other is scanned
    always_ff @(posedge clk)
    begin
        if (load_i.pix_we)
            img_q[load_i.img_sel][load_i.img_row][load_i.img_col] <= pixel_i;
    end

    // ==================================================================
    // 3x3 multiply-accumulate
    // ==================================================================
    always_comb
    begin
        mac_sum = '0;
        for (int r = 0; r < cnn_pkg::KER_DIM; r++)
        begin
            for (int c = 0; c < cnn_pkg::KER_DIM; c++)
            begin
                mac_sum = mac_sum +
                          img_q[cmd_i.img_sel][cmd_i.row + r][cmd_i.col + c] *
                          ker_q[r * cnn_pkg::KER_DIM + c];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sum_q <= '0;
        else if (cmd_i.valid)
            sum_q <= mac_sum;   // one cycle after the command
    end

    assign sum_o = sum_q;

endmodule

//--- src/dense_layer.sv
`timescale 1ns/1ps

module dense_layer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cnn_pkg::load_ctrl_t     load_i,
    input  cnn_pkg::pixel_t         weight_i,
    input  cnn_pkg::pooled_vec_t    pooled_i,
    output logic                    out_valid_o,
    output cnn_pkg::out_t           out_data_o
);

    cnn_pkg::pixel_t                        wgt_q [cnn_pkg::N_OUT][cnn_pkg::N_FEAT];
    cnn_pkg::pixel_t [cnn_pkg::N_FEAT-1:0]  feat_q;
    logic                                   busy;
    logic [$clog2(cnn_pkg::N_OUT)-1:0]      out_idx;
    cnn_pkg::out_t                          dot_sum;
    logic                                   out_valid_q;
    cnn_pkg::out_t                          out_data_q;

    // ==================================================================
    // weight table and feature capture
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (load_i.wgt_we)
            wgt_q[load_i.wgt_row][load_i.wgt_col] <= weight_i;
    end

    always_ff @(posedge clk)
    begin
        if (pooled_i.valid)
            feat_q <= pooled_i.feat;
    end

    // ==================================================================
    // output sequencer, one row per cycle
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            out_idx <= '0;
        end
        else if (pooled_i.valid)
        begin
            busy    <= 1'b1;
            out_idx <= '0;
        end
        else if (busy)
        begin
            out_idx <= out_idx + 1'b1;
            if (out_idx == 2'(cnn_pkg::N_OUT - 1))
                busy <= 1'b0;
        end
    end

    always_comb
    begin
        dot_sum = '0;
        for (int f = 0; f < cnn_pkg::N_FEAT; f++)
        begin
            dot_sum = dot_sum + feat_q[f] * wgt_q[out_idx][f];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid_q <= 1'b0;
            out_data_q  <= '0;
        end
        else
        begin
            out_valid_q <= busy;
            out_data_q  <= busy ? dot_sum : '0;     // zero between results
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

endmodule

//--- src/feature_pool.sv
`timescale 1ns/1ps

module feature_pool (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cnn_pkg::act_mode_t      mode_i,
    input  cnn_pkg::conv_cmd_t      cmd_i,
    input  cnn_pkg::conv_sum_t      sum_a_i,
    input  cnn_pkg::conv_sum_t      sum_b_i,
    output cnn_pkg::pooled_vec_t    pooled_o
);

    cnn_pkg::conv_cmd_t cmd_d;
    cnn_pkg::fmap_t     chan_sum;
    cnn_pkg::fmap_t     act_val;
    cnn_pkg::fmap_t     max_q [cnn_pkg::N_FEAT];
    logic [2:0]         win_idx;
    logic               win_first;
    logic               win_last;
    logic               pool_valid_q;

    // activation output is never negative, so only the upper bound is checked
    function automatic cnn_pkg::pixel_t quantize(input cnn_pkg::fmap_t v);
        cnn_pkg::fmap_t shifted;
        shifted = v >>> cnn_pkg::QUANT_SHIFT;
        if (shifted > cnn_pkg::QUANT_MAX)
            return cnn_pkg::pixel_t'(cnn_pkg::QUANT_MAX);
        else
            return cnn_pkg::pixel_t'(shifted);
    endfunction

    // ==================================================================
    // channel sum and activation
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cmd_d <= '0;
        else
            cmd_d <= cmd_i;     // lines up with the registered sums
    end

    assign chan_sum = cnn_pkg::fmap_t'(sum_a_i) + cnn_pkg::fmap_t'(sum_b_i);

    always_comb
    begin
        if (chan_sum >= 0)
            act_val = chan_sum;
        else if (mode_i == cnn_pkg::ACT_ABS)
            act_val = -chan_sum;
        else
            act_val = '0;       // relu
    end

    // ==================================================================
    // 2x2 max pooling
    // ==================================================================
    assign win_idx = 3'(cmd_d.img_sel * (cnn_pkg::N_FEAT / cnn_pkg::N_IMAGES) +
                        (cmd_d.row / cnn_pkg::POOL_DIM) *
                        (cnn_pkg::FMAP_DIM / cnn_pkg::POOL_DIM) +
                        cmd_d.col / cnn_pkg::POOL_DIM);
    assign win_first = (cmd_d.row % cnn_pkg::POOL_DIM == 0) &&
                       (cmd_d.col % cnn_pkg::POOL_DIM == 0);
    assign win_last = cmd_d.valid && cmd_d.img_sel &&
                      (cmd_d.row == 2'(cnn_pkg::FMAP_DIM - 1)) &&
                      (cmd_d.col == 2'(cnn_pkg::FMAP_DIM - 1));

    always_ff @(posedge clk)
    begin
        if (cmd_d.valid)
        begin
            if (win_first || (act_val > max_q[win_idx]))
                max_q[win_idx] <= act_val;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pool_valid_q <= 1'b0;
        else
            pool_valid_q <= win_last;   // single-cycle strobe
    end

    // ==================================================================
    // quantized output vector
    // ==================================================================
    always_comb
    begin
        pooled_o.valid = pool_valid_q;
        for (int i = 0; i < cnn_pkg::N_FEAT; i++)
        begin
            pooled_o.feat[i] = quantize(max_q[i]);
        end
    end

endmodule

//--- verif/cnn_asserts.sv
`timescale 1ns/1ps

module cnn_asserts (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid_i,
    input  logic            out_valid_o,
    input  cnn_pkg::out_t   out_data_o
);

    // four results, then the strobe drops
    strobe_len_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid_o) |-> out_valid_o [*4] ##1 !out_valid_o)
        else $error("out_valid_o burst is not exactly four cycles long");

    idle_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid_o |-> (out_data_o == '0))
        else $error("out_data_o is not zero while out_valid_o is low");

    no_overlap_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid_o && in_valid_i))
        else $error("out_valid_o is high during an input transaction");

endmodule

//--- verif/cnn_tb.sv
`timescale 1ns/1ps

module cnn_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int FIRST_TIMEOUT = 300;     // cycles from last sample to first strobe
    localparam int DRAIN_TIMEOUT = 20;

    logic               clk;
    logic               rst_n;
    logic               in_valid_i;
    logic               mode_i;
    cnn_pkg::pixel_t    in_data_ch1_i;
    cnn_pkg::pixel_t    in_data_ch2_i;
    cnn_pkg::pixel_t    kernel_ch1_i;
    cnn_pkg::pixel_t    kernel_ch2_i;
    cnn_pkg::pixel_t    weight_i;
    logic               out_valid_o;
    cnn_pkg::out_t      out_data_o;

    logic [31:0]        lfsr_state;
    logic               mode_s;
    cnn_pkg::pixel_t    ker1_s [cnn_pkg::KER_SAMPLES];
    cnn_pkg::pixel_t    ker2_s [cnn_pkg::KER_SAMPLES];
    cnn_pkg::pixel_t    wgt_s  [cnn_pkg::WEIGHT_SAMPLES];
    cnn_pkg::pixel_t    pix1_s [cnn_pkg::TXN_SAMPLES];   // both images, channel 1
    cnn_pkg::pixel_t    pix2_s [cnn_pkg::TXN_SAMPLES];
    cnn_pkg::out_t      exp_q [$];
    int                 value_errors;
    int                 timeout_errors;
    int                 protocol_errors;
    int                 strobe_cnt;
    int                 exp_strobes;
    bit                 timed_out;

    cnn_top cnn_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid_i    (in_valid_i),
        .mode_i        (mode_i),
        .in_data_ch1_i (in_data_ch1_i),
        .in_data_ch2_i (in_data_ch2_i),
        .kernel_ch1_i  (kernel_ch1_i),
        .kernel_ch2_i  (kernel_ch2_i),
        .weight_i      (weight_i),
        .out_valid_o   (out_valid_o),
        .out_data_o    (out_data_o)
    );

    bind cnn_top cnn_asserts cnn_asserts_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================================
    // stimulus generation
    // ==================================================================
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic cnn_pkg::pixel_t rand_pixel();
        cnn_pkg::pixel_t v;
        for (int b = 0; b < 8; b++)
            v[b] = lfsr_bit();
        return v;
    endfunction

    task automatic fill_random(input logic mode);
        mode_s = mode;
        for (int i = 0; i < cnn_pkg::KER_SAMPLES; i++)
        begin
            ker1_s[i] = rand_pixel();
            ker2_s[i] = rand_pixel();
        end
        for (int i = 0; i < cnn_pkg::WEIGHT_SAMPLES; i++)
            wgt_s[i] = rand_pixel();
        for (int i = 0; i < cnn_pkg::TXN_SAMPLES; i++)
        begin
            pix1_s[i] = rand_pixel();
            pix2_s[i] = rand_pixel();
        end
    endtask

    task automatic fill_saturated(input logic mode);
        fill_random(mode);     // keeps the random weights
        for (int i = 0; i < cnn_pkg::KER_SAMPLES; i++)
        begin
            ker1_s[i] = 8'sd127;
            ker2_s[i] = 8'sd127;
        end
        for (int i = 0; i < cnn_pkg::TXN_SAMPLES; i++)
        begin
            pix1_s[i] = 8'sd127;
            pix2_s[i] = 8'sd127;
        end
    endtask

    // ==================================================================
    // reference model
    // ==================================================================
    function automatic void predict_outputs();
        int s1;
        int s2;
        int act;
        int win;
        int acc;
        int best [8];
        int feat [8];
        for (int w = 0; w < 8; w++)
            best[w] = -1;
        for (int img = 0; img < 2; img++)
            for (int r = 0; r < 4; r++)
                for (int c = 0; c < 4; c++)
                begin
                    s1 = 0;
                    s2 = 0;
                    for (int kr = 0; kr < 3; kr++)
                        for (int kc = 0; kc < 3; kc++)
                        begin
                            s1 += pix1_s[img * 36 + (r + kr) * 6 + c + kc] * ker1_s[kr * 3 + kc];
                            s2 += pix2_s[img * 36 + (r + kr) * 6 + c + kc] * ker2_s[kr * 3 + kc];
                        end
                    act = s1 + s2;
                    if (act < 0)
                        act = mode_s ? -act : 0;
                    win = img * 4 + (r / 2) * 2 + c / 2;
                    if (act > best[win])
                        best[win] = act;
                end
        for (int w = 0; w < 8; w++)
        begin
            feat[w] = best[w] >>> 9;
            if (feat[w] > 127)
                feat[w] = 127;
        end
        for (int o = 0; o < 4; o++)
        begin
            acc = 0;
            for (int f = 0; f < 8; f++)
                acc += feat[f] * wgt_s[o * 8 + f];
            exp_q.push_back(cnn_pkg::out_t'(acc));
        end
    endfunction

    // ==================================================================
    // drive and wait
    // ==================================================================
    task automatic set_idle_inputs();
        in_valid_i    = 1'b0;
        mode_i        = 1'b0;
        in_data_ch1_i = '0;
        in_data_ch2_i = '0;
        kernel_ch1_i  = '0;
        kernel_ch2_i  = '0;
        weight_i      = '0;
    endtask

    task automatic drive_txn();
        for (int n = 0; n < cnn_pkg::TXN_SAMPLES; n++)
        begin
            @(posedge clk);
            #1;
            in_valid_i    = 1'b1;
            mode_i        = (n == 0) ? mode_s : 1'b0;
            in_data_ch1_i = pix1_s[n];
            in_data_ch2_i = pix2_s[n];
            kernel_ch1_i  = (n < cnn_pkg::KER_SAMPLES) ? ker1_s[n] : '0;
            kernel_ch2_i  = (n < cnn_pkg::KER_SAMPLES) ? ker2_s[n] : '0;
            weight_i      = (n < cnn_pkg::WEIGHT_SAMPLES) ? wgt_s[n] : '0;
        end
        @(posedge clk);
        #1;
        set_idle_inputs();
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (!out_valid_o && cycles < FIRST_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid_o)
        begin
            $display("timeout: no output strobe appeared after the transaction");
            timeout_errors++;
            timed_out = 1'b1;
        end
        else
        begin
            cycles = 0;
            while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT)
            begin
                @(posedge clk);
                cycles++;
            end
            if (exp_q.size() != 0)
            begin
                $display("timeout: fewer than four results arrived");
                timeout_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic run_txn(input bit sat_check);
        int row_sum;
        if (sat_check)
            for (int o = 0; o < 4; o++)
            begin
                row_sum = 0;
                for (int f = 0; f < 8; f++)
                    row_sum += wgt_s[o * 8 + f];
                exp_q.push_back(cnn_pkg::out_t'(127 * row_sum));   // every feature at 127
            end
        else
            predict_outputs();
        exp_strobes += 4;
        drive_txn();
        wait_results();
        if (!timed_out)
        begin
            repeat (3) @(posedge clk);
            assert (strobe_cnt == exp_strobes)
            else
            begin
                $display("saw %0d output strobes where %0d were due", strobe_cnt, exp_strobes);
                protocol_errors++;
            end
        end
    endtask

    // ==================================================================
    // comparison
    // ==================================================================
    always @(negedge clk)
    begin
        cnn_pkg::out_t exp_val;
        if (rst_n && out_valid_o)
        begin
            strobe_cnt++;
            if (exp_q.size() == 0)
            begin
                $display("an output strobe arrived with no result expected");
                protocol_errors++;
            end
            else
            begin
                exp_val = exp_q.pop_front();
                assert (out_data_o === exp_val)
                else
                begin
                    $display("ERROR out_data_o got %h expected %h", out_data_o, exp_val);
                    value_errors++;
                end
            end
        end
    end

    initial
    begin
        set_idle_inputs();
        rst_n           = 1'b0;
        lfsr_state      = 32'hc577_b3b5;
        mode_s          = 1'b0;
        value_errors    = 0;
        timeout_errors  = 0;
        protocol_errors = 0;
        strobe_cnt      = 0;
        exp_strobes     = 0;
        timed_out       = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // quiet outputs before any input
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            assert (out_valid_o == 1'b0)
            else
            begin
                $display("ERROR out_valid_o got %h expected %h", out_valid_o, 1'b0);
                value_errors++;
            end
            assert (out_data_o == '0)
            else
            begin
                $display("ERROR out_data_o got %h expected %h", out_data_o, 20'h0);
                value_errors++;
            end
        end

        fill_random(1'b0);
        run_txn(1'b0);
        if (!timed_out)
        begin
            mode_s = 1'b1;      // same images, abs mode
            run_txn(1'b0);
        end
        if (!timed_out)
        begin
            fill_saturated(1'b0);
            run_txn(1'b1);
        end
        for (int t = 0; t < 3 && !timed_out; t++)
        begin
            fill_random(t == 1);
            run_txn(1'b0);
        end

        $display("errors: value %0d, timeout %0d, protocol %0d",
                 value_errors, timeout_errors, protocol_errors);
        if (value_errors == 0 && timeout_errors == 0 && protocol_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- verilog.f
src/cnn_pkg.sv
src/cnn_ctrl.sv
src/conv_channel.sv
src/feature_pool.sv
src/dense_layer.sv
src/cnn_top.sv
verif/cnn_asserts.sv
verif/cnn_tb.sv
